/* xlate_top.f */
hw/xlate_pkg.sv
hw/xlate_req_buffer.sv
hw/xlate_dram_map.sv
hw/xlate_mesh_decode.sv
hw/xlate_npa_merge.sv
hw/xlate_top.sv
verif/xlate_assert.sv
verif/xlate_tb.sv

/* Bender.yml */
package:
  name: xlate

sources:
  - files:
      - hw/xlate_pkg.sv
      - hw/xlate_req_buffer.sv
      - hw/xlate_dram_map.sv
      - hw/xlate_mesh_decode.sv
      - hw/xlate_npa_merge.sv
      - hw/xlate_top.sv

  - target: simulation
    files:
      - verif/xlate_assert.sv
      - verif/xlate_tb.sv

/* verif/xlate_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module xlate_tb;

  localparam int num_tiles_x_lp  = 4;
  localparam int num_tiles_y_lp  = 4;
  localparam int block_words_lp  = 8;
  localparam int vcache_words_lp = 512;
  localparam int in_credits_lp   = 4;
  localparam int out_credits_lp  = 2;
  localparam int cycle_limit_lp  = 3000;  // per wait loop
  localparam int x_w_lp          = xlate_pkg::x_cord_width_gp;
  localparam int y_w_lp          = xlate_pkg::y_cord_width_gp;
  localparam int epa_w_lp        = xlate_pkg::epa_width_gp;

  logic                clk = 1'b0;
  logic                arst_n;
  logic                req_v;
  xlate_pkg::eva_req_s req;
  logic                dram_enable;
  logic [x_w_lp-1:0]   tgo_x;
  logic [y_w_lp-1:0]   tgo_y;
  logic                credit_ret;   // credit from receiver to DUT
  logic                credit_back;  // credit from DUT to sender
  logic                npa_v;
  xlate_pkg::npa_s     npa;

  xlate_pkg::npa_s exp_q[$];  // expected NPAs in send order
  int   errors, checks, up_credits, pending_ret, to_send, sent, received, credit_pulses;
  int   base_out, base_cred;
  logic hold;       // receiver keeps credits back
  logic timed_out;
  logic [xlate_pkg::tag_width_gp-1:0] next_tag;

  xlate_top #(
    .num_tiles_x_p  (num_tiles_x_lp),
    .num_tiles_y_p  (num_tiles_y_lp),
    .block_words_p  (block_words_lp),
    .vcache_words_p (vcache_words_lp),
    .in_credits_p   (in_credits_lp),
    .out_credits_p  (out_credits_lp)
  ) uut (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .req_v_i       (req_v),
    .req_i         (req),
    .dram_enable_i (dram_enable),
    .tgo_x_i       (tgo_x),
    .tgo_y_i       (tgo_y),
    .credit_i      (credit_ret),
    .credit_o      (credit_back),
    .npa_v_o       (npa_v),
    .npa_o         (npa)
  );

  always #50 clk = ~clk;  // 100 ns period

  // reference translation straight from the address map rules
  function automatic xlate_pkg::npa_s expect_npa(xlate_pkg::eva_req_s r, logic dram_on,
                                                 logic [x_w_lp-1:0] tx, logic [y_w_lp-1:0] ty);
    xlate_pkg::npa_s n;
    longint unsigned eva, word, block, bank;
    eva  = 64'(r.eva);
    word = eva / 4;
    n     = '0;
    n.tag = r.tag;
    if (r.eva[31]) begin
      if (dram_on) begin
        block    = (eva % (64'd1 << 31)) / (4 * block_words_lp);  // bits 30..2 per block
        bank     = block % (2 * num_tiles_x_lp);
        n.x_cord = x_w_lp'(bank % num_tiles_x_lp);
        n.y_cord = (bank >= num_tiles_x_lp) ? y_w_lp'(num_tiles_y_lp + 1) : '0;
        n.epa    = epa_w_lp'((block / (2 * num_tiles_x_lp)) * block_words_lp
                             + word % block_words_lp);
      end else if (r.eva[30]) begin
        n.y_cord = y_w_lp'(1);  // host sits at (0,1)
        n.epa    = epa_w_lp'((64'd1 << 27) + word % (64'd1 << 27));
      end else begin
        n.x_cord = x_w_lp'((word / vcache_words_lp) % (1 << x_w_lp));
        n.y_cord = ((word / vcache_words_lp / (1 << x_w_lp)) % 2 == 1)
                   ? y_w_lp'(num_tiles_y_lp + 1) : '0;
        n.epa    = epa_w_lp'(word % vcache_words_lp);
      end
    end else if (r.eva[31:30] == 2'b01) begin
      n.x_cord = r.eva[23:18];
      n.y_cord = r.eva[28:24];
      n.epa    = epa_w_lp'(r.eva[17:2]);
    end else if (r.eva[31:29] == 3'b001) begin
      n.x_cord = x_w_lp'((int'(r.eva[23:18]) + int'(tx)) % (1 << x_w_lp));  // wraps
      n.y_cord = y_w_lp'((int'(r.eva[28:24]) + int'(ty)) % (1 << y_w_lp));
      n.epa    = epa_w_lp'(r.eva[17:2]);
    end else begin
      n.invalid = 1'b1;
    end
    return n;
  endfunction

  task automatic check_field(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_npa();
    xlate_pkg::npa_s e;
    if (exp_q.size() == 0) begin
      errors++;
      $display("NPA issued at %0t with no request outstanding", $time);
    end else begin
      e = exp_q.pop_front();
      check_field("npa_o.tag", 32'(npa.tag), 32'(e.tag));  // order check
      check_field("npa_o.invalid", 32'(npa.invalid), 32'(e.invalid));
      check_field("npa_o.x_cord", 32'(npa.x_cord), 32'(e.x_cord));
      check_field("npa_o.y_cord", 32'(npa.y_cord), 32'(e.y_cord));
      check_field("npa_o.epa", 32'(npa.epa), 32'(e.epa));
    end
  endtask

  // random class mix of roughly 40/25/20/15
  task automatic send_one();
    xlate_pkg::eva_req_s r;
    int pick;
    pick  = $urandom_range(0, 99);
    r.eva = $urandom();
    if (pick < 40)      r.eva[31]    = 1'b1;
    else if (pick < 65) r.eva[31:30] = 2'b01;
    else if (pick < 85) r.eva[31:29] = 3'b001;
    else                r.eva[31:29] = 3'b000;  // no class
    r.tag    = next_tag;
    next_tag = next_tag + 1'b1;
    req      = r;
    req_v    = 1'b1;
    exp_q.push_back(expect_npa(r, dram_enable, tgo_x, tgo_y));
    up_credits--;
    to_send--;
    sent++;
  endtask

  // sample outputs after the edge then drive the next inputs
  task automatic step();
    @(posedge clk);
    #1;
    if (credit_back) begin
      credit_pulses++;
      up_credits++;
    end
    if (up_credits > in_credits_lp) begin
      errors++;
      $display("credit_o returned more credits than were spent at %0t", $time);
    end
    if (npa_v) begin
      check_npa();
      received++;
      pending_ret++;  // owe the DUT one credit
    end
    req_v = 1'b0;
    if (to_send > 0 && up_credits > 0 && $urandom_range(0, 3) != 0) send_one();
    credit_ret = 1'b0;
    if (!hold && pending_ret > 0 && $urandom_range(0, 2) != 0) begin
      credit_ret = 1'b1;  // random return delay
      pending_ret--;
    end
  endtask

  task automatic run_until_drained(string what);
    int cycles;
    cycles = 0;
    while (!timed_out && (to_send > 0 || exp_q.size() != 0)) begin
      step();
      cycles++;
      if (cycles > cycle_limit_lp) begin
        timed_out = 1'b1;
        errors++;
        $display("timeout at %0t in %s: %0d unsent, %0d NPAs missing",
                 $time, what, to_send, exp_q.size());
      end
    end
  endtask

  initial begin
    void'($urandom(32'h579e_67b2));
    arst_n      = 1'b0;
    req_v       = 1'b0;
    req         = '0;
    dram_enable = 1'b1;
    tgo_x       = '0;
    tgo_y       = '0;
    credit_ret  = 1'b0;
    hold        = 1'b0;
    timed_out   = 1'b0;
    next_tag    = '0;
    errors      = 0;
    checks      = 0;
    pending_ret = 0;
    to_send     = 0;
    sent        = 0;
    received    = 0;
    credit_pulses = 0;
    up_credits  = in_credits_lp;
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;
    checks++;
    if (npa_v !== 1'b0 || credit_back !== 1'b0) begin
      errors++;
      $display("npa_v_o or credit_o not low after reset");
    end

    // striped DRAM plus mesh classes
    tgo_x   = x_w_lp'($urandom_range(0, (1 << x_w_lp) - 1));
    tgo_y   = y_w_lp'($urandom_range(0, (1 << y_w_lp) - 1));
    to_send = 80;
    run_until_drained("DRAM striping phase");

    // block memory and host mapping with a new origin
    dram_enable = 1'b0;
    tgo_x   = x_w_lp'($urandom_range(0, (1 << x_w_lp) - 1));
    tgo_y   = y_w_lp'($urandom_range(0, (1 << y_w_lp) - 1));
    to_send = 80;
    run_until_drained("block memory phase");

    // hold downstream credits back for a while
    hold      = 1'b1;
    to_send   = 8;
    base_out  = received;
    base_cred = credit_pulses;
    repeat (20) step();
    checks++;
    if (received - base_out > out_credits_lp) begin
      errors++;
      $display("%0d NPAs issued while credits were held, limit is %0d",
               received - base_out, out_credits_lp);
    end
    checks++;
    if (credit_pulses - base_cred != received - base_out) begin
      errors++;
      $display("credit_o pulses during hold do not match popped requests");
    end
    hold = 1'b0;
    run_until_drained("credit release phase");

    checks++;
    if (!timed_out && credit_pulses != sent) begin
      errors++;
      $display("credit_o pulsed %0d times for %0d requests", credit_pulses, sent);
    end

    errors += uut.u_xlate_assert.fail_count;  // bound assertion failures
    $display("checks %0d errors %0d requests %0d NPAs %0d", checks, errors, sent, received);
    if (!timed_out && errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/xlate_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module xlate_assert #(
  parameter int depth_p       = 4,
  parameter int out_credits_p = 2
) (
  input wire logic            clk_i,
  input wire logic            arst_n_i,
  input wire logic            req_v_i,
  input wire logic            pop_i,
  input wire logic            credit_i,
  input wire logic            credit_o,
  input wire logic            npa_v_o,
  input wire xlate_pkg::npa_s npa_o
);

  int occ_r;           // shadow of request buffer fill
  int cred_r;          // shadow of downstream credits held
  int fail_count = 0;  // assertion failures so far

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      occ_r  <= 0;
      cred_r <= out_credits_p;
    end else begin
      occ_r  <= occ_r + int'(req_v_i) - int'(pop_i);
      cred_r <= cred_r - int'(pop_i) + int'(credit_i);
    end
  end

  a_npa_needs_credit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    npa_v_o |-> $past(cred_r) > 0) else begin
    fail_count++;
    $error("NPA issued with no downstream credit");
  end

  // credit goes back with the NPA of an entry that was really buffered
  a_credit_for_entry: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    credit_o |-> npa_v_o && $past(occ_r) > 0) else begin
    fail_count++;
    $error("credit_o without a dequeued entry");
  end

  a_npa_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    npa_v_o |-> !$isunknown(npa_o)) else begin
    fail_count++;
    $error("npa_o has unknown bits while valid");
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (req_v_i && !pop_i) |-> occ_r < depth_p) else begin
    fail_count++;
    $error("request buffer overflow");
  end

endmodule

bind xlate_top xlate_assert #(
  .depth_p       (in_credits_p),
  .out_credits_p (out_credits_p)
) u_xlate_assert (
  .clk_i    (clk_i),
  .arst_n_i (arst_n_i),
  .req_v_i  (req_v_i),
  .pop_i    (pop),
  .credit_i (credit_i),
  .credit_o (credit_o),
  .npa_v_o  (npa_v_o),
  .npa_o    (npa_o)
);

`default_nettype wire

/* hw/xlate_top.sv */
`timescale 1ns/1ps
`default_nettype none

module xlate_top #(
  parameter int num_tiles_x_p  = 4,
  parameter int num_tiles_y_p  = 4,
  parameter int block_words_p  = 8,
  parameter int vcache_words_p = 512,
  parameter int in_credits_p   = 4,   // sender credits, also buffer depth
  parameter int out_credits_p  = 2
) (
  input  wire logic                                  clk_i,
  input  wire logic                                  arst_n_i,
  input  wire logic                                  req_v_i,
  input  xlate_pkg::eva_req_s                        req_i,
  input  wire logic                                  dram_enable_i,  // quasi-static
  input  wire logic [xlate_pkg::x_cord_width_gp-1:0] tgo_x_i,
  input  wire logic [xlate_pkg::y_cord_width_gp-1:0] tgo_y_i,
  input  wire logic                                  credit_i,
  output logic                                       credit_o,
  output logic                                       npa_v_o,
  output xlate_pkg::npa_s                            npa_o
);

  logic                head_v;
  xlate_pkg::eva_req_s head;
  logic                pop;
  xlate_pkg::mapped_s  dram_res, mesh_res;
  logic                is_dram, is_global, is_tile_group;

  // request buffer, one entry per upstream credit
  xlate_req_buffer #(
    .depth_p (in_credits_p)
  ) u_req_buffer (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (req_v_i),
    .data_i   (req_i),
    .pop_i    (pop),
    .valid_o  (head_v),
    .data_o   (head),
    .credit_o (credit_o)
  );

  // both decoders look at the head in parallel
  xlate_dram_map #(
    .num_tiles_x_p  (num_tiles_x_p),
    .num_tiles_y_p  (num_tiles_y_p),
    .block_words_p  (block_words_p),
    .vcache_words_p (vcache_words_p)
  ) u_dram_map (
    .eva_i         (head.eva),
    .dram_enable_i (dram_enable_i),
    .res_o         (dram_res)
  );

  xlate_mesh_decode u_mesh_decode (
    .eva_i           (head.eva),
    .tgo_x_i         (tgo_x_i),
    .tgo_y_i         (tgo_y_i),
    .res_o           (mesh_res),
    .is_dram_o       (is_dram),
    .is_global_o     (is_global),
    .is_tile_group_o (is_tile_group)
  );

  xlate_npa_merge #(
    .out_credits_p (out_credits_p)
  ) u_npa_merge (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .head_v_i        (head_v),
    .head_tag_i      (head.tag),
    .dram_res_i      (dram_res),
    .mesh_res_i      (mesh_res),
    .is_dram_i       (is_dram),
    .is_global_i     (is_global),
    .is_tile_group_i (is_tile_group),
    .credit_i        (credit_i),
    .pop_o           (pop),
    .npa_v_o         (npa_v_o),
    .npa_o           (npa_o)
  );

endmodule

`default_nettype wire

/* hw/xlate_npa_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module xlate_npa_merge #(
  parameter int out_credits_p = 2
) (
  input  wire logic                              clk_i,
  input  wire logic                              arst_n_i,
  input  wire logic                              head_v_i,
  input  wire logic [xlate_pkg::tag_width_gp-1:0] head_tag_i,
  input  xlate_pkg::mapped_s                     dram_res_i,
  input  xlate_pkg::mapped_s                     mesh_res_i,
  input  wire logic                              is_dram_i,
  input  wire logic                              is_global_i,
  input  wire logic                              is_tile_group_i,
  input  wire logic                              credit_i,   // one credit back from receiver
  output logic                                   pop_o,
  output logic                                   npa_v_o,
  output xlate_pkg::npa_s                        npa_o
);

  localparam int cnt_w_lp = $clog2(out_credits_p + 1);

  logic [cnt_w_lp-1:0] credits_r;  // downstream credits held
  xlate_pkg::npa_s     npa_d;
  logic                npa_v_r;

  assign pop_o = head_v_i & (credits_r != '0);

  // pick result by class
  always_comb begin
    npa_d.tag     = head_tag_i;
    npa_d.invalid = 1'b0;
    if (is_dram_i) begin
      npa_d.x_cord = dram_res_i.x_cord;
      npa_d.y_cord = dram_res_i.y_cord;
      npa_d.epa    = dram_res_i.epa;
    end else if (is_global_i || is_tile_group_i) begin
      npa_d.x_cord = mesh_res_i.x_cord;
      npa_d.y_cord = mesh_res_i.y_cord;
      npa_d.epa    = mesh_res_i.epa;
    end else begin
      npa_d.x_cord  = '0;  // no class
      npa_d.y_cord  = '0;
      npa_d.epa     = '0;
      npa_d.invalid = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) npa_o <= npa_d;  // hold last NPA otherwise
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      npa_v_r   <= 1'b0;
      credits_r <= cnt_w_lp'(out_credits_p);  // full at reset
    end else begin
      npa_v_r <= pop_o;
      if (pop_o && !credit_i)      credits_r <= credits_r - 1'b1;
      else if (!pop_o && credit_i) credits_r <= credits_r + 1'b1;
    end
  end

  assign npa_v_o = npa_v_r;

endmodule

`default_nettype wire

/* hw/xlate_mesh_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module xlate_mesh_decode (
  input  wire logic [xlate_pkg::eva_width_gp-1:0]    eva_i,
  input  wire logic [xlate_pkg::x_cord_width_gp-1:0] tgo_x_i,  // tile-group origin
  input  wire logic [xlate_pkg::y_cord_width_gp-1:0] tgo_y_i,
  output xlate_pkg::mapped_s                         res_o,
  output logic                                       is_dram_o,
  output logic                                       is_global_o,
  output logic                                       is_tile_group_o
);

  xlate_pkg::mesh_addr_s view;  // field view of the EVA

  assign view = eva_i;

  // classify
  assign is_dram_o       = xlate_pkg::is_dram_class(eva_i);
  assign is_global_o     = xlate_pkg::is_global_class(eva_i);
  assign is_tile_group_o = xlate_pkg::is_tile_group_class(eva_i);

  always_comb begin
    res_o.x_cord = '0;
    res_o.y_cord = '0;
    res_o.epa    = xlate_pkg::epa_width_gp'(view.addr);  // word addr, same for both

    if (is_global_o) begin
      // coordinates are absolute
      res_o.x_cord = view.x_cord;
      res_o.y_cord = view.y_cord;
    end else if (is_tile_group_o) begin
      // relative to origin, wraps at coordinate width
      res_o.x_cord = xlate_pkg::x_cord_width_gp'(view.x_cord + tgo_x_i);
      res_o.y_cord = xlate_pkg::y_cord_width_gp'(view.y_cord + tgo_y_i);
    end else begin
      res_o.epa = '0;  // dram or invalid, merge ignores this side
    end
  end

endmodule

`default_nettype wire

/* hw/xlate_dram_map.sv */
`timescale 1ns/1ps
`default_nettype none

module xlate_dram_map #(
  parameter int num_tiles_x_p  = 4,
  parameter int num_tiles_y_p  = 4,
  parameter int block_words_p  = 8,    // vcache block size in words
  parameter int vcache_words_p = 512   // vcache capacity in words
) (
  input  wire logic [xlate_pkg::eva_width_gp-1:0] eva_i,
  input  wire logic                               dram_enable_i,
  output xlate_pkg::mapped_s                      res_o
);

  localparam int word_off_w_lp = $clog2(block_words_p);
  localparam int lg_vcache_lp  = $clog2(vcache_words_p);
  localparam int banks_lp      = 2 * num_tiles_x_p;  // top row plus bottom row
  localparam int lg_banks_lp   = $clog2(banks_lp);
  // bits 30 down to 2 + word offset
  localparam int block_w_lp    = xlate_pkg::eva_width_gp - 3 - word_off_w_lp;
  localparam int set_w_lp      = block_w_lp - lg_banks_lp;
  // block-memory y select sits right above the x field
  localparam int bm_ysel_lp    = 2 + lg_vcache_lp + xlate_pkg::x_cord_width_gp;

  logic [block_w_lp-1:0]    block_num;
  logic [word_off_w_lp-1:0] word_off;
  logic [lg_banks_lp-1:0]   bank;
  logic [set_w_lp-1:0]      set_idx;

  assign block_num = eva_i[2+word_off_w_lp +: block_w_lp];
  assign word_off  = eva_i[2 +: word_off_w_lp];
  assign bank      = lg_banks_lp'(block_num % banks_lp);  // pow2 so just low bits
  assign set_idx   = set_w_lp'(block_num / banks_lp);

  always_comb begin
    if (dram_enable_i) begin
      // striped across the vcache banks, one block per bank
      res_o.x_cord = xlate_pkg::x_cord_width_gp'(bank % num_tiles_x_p);
      res_o.y_cord = bank[lg_banks_lp-1]
        ? xlate_pkg::y_cord_width_gp'(num_tiles_y_p + 1)  // south vcache row
        : '0;                                             // north vcache row
      res_o.epa    = xlate_pkg::epa_width_gp'({set_idx, word_off});
    end else if (eva_i[30]) begin
      // host memory behind the io tile
      res_o.x_cord = '0;
      res_o.y_cord = xlate_pkg::y_cord_width_gp'(1);
      res_o.epa    = {1'b1, eva_i[28:2]};
    end else begin
      // block memory, no striping
      res_o.x_cord = eva_i[2+lg_vcache_lp +: xlate_pkg::x_cord_width_gp];
      res_o.y_cord = eva_i[bm_ysel_lp]
        ? xlate_pkg::y_cord_width_gp'(num_tiles_y_p + 1)
        : '0;
      res_o.epa    = xlate_pkg::epa_width_gp'(eva_i[2 +: lg_vcache_lp]);
    end
  end

endmodule

`default_nettype wire

/* hw/xlate_req_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module xlate_req_buffer #(
  parameter int depth_p = 4  // matches upstream credit count
) (
  input  wire logic               clk_i,
  input  wire logic               arst_n_i,
  input  wire logic               push_i,
  input  xlate_pkg::eva_req_s     data_i,
  input  wire logic               pop_i,
  output logic                    valid_o,
  output xlate_pkg::eva_req_s     data_o,
  output logic                    credit_o   // one pulse per dequeued entry
);

  localparam int ptr_w_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int cnt_w_lp = $clog2(depth_p + 1);

  xlate_pkg::eva_req_s mem [depth_p];  // entry storage

  logic [ptr_w_lp-1:0] wr_ptr_r, rd_ptr_r;
  logic [cnt_w_lp-1:0] count_r;
  logic                credit_r;

  // circular increment, depth need not be a power of two
  function automatic logic [ptr_w_lp-1:0] ptr_next(logic [ptr_w_lp-1:0] p);
    return (p == ptr_w_lp'(depth_p - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge clk_i) begin
    if (push_i) mem[wr_ptr_r] <= data_i;  // payload only
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
      credit_r <= 1'b0;
    end else begin
      if (push_i) wr_ptr_r <= ptr_next(wr_ptr_r);
      if (pop_i)  rd_ptr_r <= ptr_next(rd_ptr_r);
      // simultaneous push and pop leaves count alone
      if (push_i && !pop_i)      count_r <= count_r + 1'b1;
      else if (!push_i && pop_i) count_r <= count_r - 1'b1;
      credit_r <= pop_i;  // credit back the cycle after pop
    end
  end

  assign valid_o  = (count_r != '0);
  assign data_o   = mem[rd_ptr_r];  // head, read combinationally
  assign credit_o = credit_r;

endmodule

`default_nettype wire

/* hw/xlate_pkg.sv */
`default_nettype none

package xlate_pkg;

  localparam int eva_width_gp      = 32;  // core virtual byte address
  localparam int x_cord_width_gp   = 6;
  localparam int y_cord_width_gp   = 5;
  localparam int epa_width_gp      = 28;  // endpoint word address
  localparam int tag_width_gp      = 4;   // order check tag
  localparam int epa_word_width_gp = 16;  // word addr field of global / tile-group EVA

  // one incoming translation request
  typedef struct packed {
    logic [eva_width_gp-1:0] eva;
    logic [tag_width_gp-1:0] tag;
  } eva_req_s;

  // translated network physical address
  typedef struct packed {
    logic [x_cord_width_gp-1:0] x_cord;
    logic [y_cord_width_gp-1:0] y_cord;
    logic [epa_width_gp-1:0]    epa;
    logic [tag_width_gp-1:0]    tag;
    logic                       invalid;  // EVA hit no class
  } npa_s;

  // mesh view of an EVA, msb first
  typedef struct packed {
    logic [2:0]                   class_bits;
    logic [y_cord_width_gp-1:0]   y_cord;
    logic [x_cord_width_gp-1:0]   x_cord;
    logic [epa_word_width_gp-1:0] addr;
    logic [1:0]                   byte_off;
  } mesh_addr_s;

  // output of one mapper
  typedef struct packed {
    logic [x_cord_width_gp-1:0] x_cord;
    logic [y_cord_width_gp-1:0] y_cord;
    logic [epa_width_gp-1:0]    epa;
  } mapped_s;

  // class rules, mutually exclusive by construction
  function automatic logic is_dram_class(logic [eva_width_gp-1:0] eva);
    return eva[eva_width_gp-1];  // 1xx
  endfunction

  function automatic logic is_global_class(logic [eva_width_gp-1:0] eva);
    return eva[eva_width_gp-1 -: 2] == 2'b01;  // 01x
  endfunction

  function automatic logic is_tile_group_class(logic [eva_width_gp-1:0] eva);
    return eva[eva_width_gp-1 -: 3] == 3'b001;  // 001
  endfunction

endpackage

`default_nettype wire
